// File: design/lane_alu.sv
`timescale 1ns/100ps

module lane_alu import lane_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  exec_ctrl_t  ctrl_i,
    input  logic [31:0] elem_a_i,
    input  logic [31:0] elem_b_i,
    output wb_req_t     wb_o,
    output logic        store_valid_o,
    output logic [31:0] store_data_o
);

    logic [31:0] op_b;
    logic [31:0] result;
    logic        cmp_bit;
    wb_req_t     wb_d;

    // Second operand source
    always_comb begin
        case (ctrl_i.src2)
            SRC2_SCALAR: op_b = ctrl_i.scalar;
            SRC2_IMM:    op_b = ctrl_i.imm;
            default:     op_b = elem_b_i;
        endcase
    end

    always_comb begin
        cmp_bit = 1'b0;
        case (ctrl_i.alu_op)
            ALU_ADD:  result = elem_a_i + op_b;
            ALU_SUB:  result = elem_a_i - op_b;
            ALU_AND:  result = elem_a_i & op_b;
            ALU_OR:   result = elem_a_i | op_b;
            ALU_XOR:  result = elem_a_i ^ op_b;
            ALU_PASS: result = op_b;
            ALU_CMP_EQ: begin
                cmp_bit = (elem_a_i == op_b);
                result  = {31'd0, cmp_bit};
            end
            default: begin
                cmp_bit = ($signed(elem_a_i) < $signed(op_b));
                result  = {31'd0, cmp_bit};
            end
        endcase
    end

    always_comb begin
        // Stores leave the lane here and never reach writeback
        wb_d.valid    = ctrl_i.valid && (ctrl_i.kind != KIND_STORE);
        wb_d.is_mask  = (ctrl_i.kind == KIND_MASK);
        wb_d.sew      = ctrl_i.sew;
        wb_d.vd       = ctrl_i.vd;
        wb_d.masked   = ctrl_i.masked;
        wb_d.result   = result;
        wb_d.mask_bit = result[0];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o <= wb_d;
        end
    end

    // Store path, straight from the extract registers
    assign store_valid_o = ctrl_i.valid && (ctrl_i.kind == KIND_STORE);
    assign store_data_o  = ctrl_i.store_sel ? elem_b_i : elem_a_i;

endmodule

// File: design/lane_ctrl_pipe.sv
`timescale 1ns/100ps

module lane_ctrl_pipe import lane_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       op_valid_i,
    input  lane_op_t   op_i,
    output exec_ctrl_t ctrl_o
);

    exec_ctrl_t s1_d;
    exec_ctrl_t s1_q;
    exec_ctrl_t s2_q;

    always_comb begin
        s1_d.valid     = op_valid_i;
        s1_d.kind      = op_i.kind;
        s1_d.alu_op    = op_i.alu_op;
        s1_d.src2      = op_i.src2;
        s1_d.sew       = op_i.sew;
        s1_d.vd        = op_i.vd;
        s1_d.masked    = op_i.masked;
        // Immediate widened here so the ALU stage sees a full operand
        s1_d.imm       = {{27{op_i.imm_signed & op_i.imm5[4]}}, op_i.imm5};
        s1_d.scalar    = op_i.scalar;
        s1_d.store_sel = op_i.store_sel;
    end

    // Two stages to match the bank read and extract registers
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_q.valid <= 1'b0;
            s2_q.valid <= 1'b0;
        end else begin
            s1_q <= s1_d;
            s2_q <= s1_q;
        end
    end

    assign ctrl_o = s2_q;

endmodule

// File: design/lane_pkg.sv
package lane_pkg;

    // Register file geometry
    localparam int VRF_DEPTH  = 256;
    localparam int VRF_AW     = 8;
    localparam int EL_IDX_W   = 10;
    localparam int MASK_DEPTH = 32;
    localparam int MASK_AW    = 5;
    localparam int R_PORTS    = 2;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS   = 3'd5,
        ALU_CMP_EQ = 3'd6,
        ALU_CMP_LT = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_VS2    = 2'd0,
        SRC2_SCALAR = 2'd1,
        SRC2_IMM    = 2'd2
    } src2_e;

    typedef enum logic [1:0] {
        KIND_ALU   = 2'd0,
        KIND_MASK  = 2'd1,
        KIND_STORE = 2'd2
    } op_kind_e;

    // One VRF word, addressed as word, halfwords or bytes
    typedef union packed {
        logic [31:0]      w;
        logic [1:0][15:0] h;
        logic [3:0][7:0]  b;
    } vrf_word_u;

    typedef struct packed {
        op_kind_e            kind;
        alu_op_e             alu_op;
        src2_e               src2;
        sew_e                sew;
        logic [EL_IDX_W-1:0] vs1;
        logic [EL_IDX_W-1:0] vs2;
        logic [EL_IDX_W-1:0] vd;
        logic                signed_rd;
        logic [4:0]          imm5;
        logic                imm_signed;
        logic                masked;
        logic [31:0]         scalar;
        logic                store_sel;
    } lane_op_t;

    typedef struct packed {
        logic                valid;
        op_kind_e            kind;
        alu_op_e             alu_op;
        src2_e               src2;
        sew_e                sew;
        logic [EL_IDX_W-1:0] vd;
        logic                masked;
        logic [31:0]         imm;
        logic [31:0]         scalar;
        logic                store_sel;
    } exec_ctrl_t;

    typedef struct packed {
        logic                valid;
        logic                is_mask;
        sew_e                sew;
        logic [EL_IDX_W-1:0] vd;
        logic                masked;
        logic [31:0]         result;
        logic                mask_bit;
    } wb_req_t;

    // Word address of an element, shared by the read and write sides
    function automatic logic [VRF_AW-1:0] el_word_addr(logic [EL_IDX_W-1:0] idx, sew_e sew);
        case (sew)
            SEW_8:   return idx[VRF_AW+1:2];
            SEW_16:  return idx[VRF_AW:1];
            default: return idx[VRF_AW-1:0];
        endcase
    endfunction

endpackage

// File: design/lane_writeback.sv
`timescale 1ns/100ps

module lane_writeback import lane_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  wb_req_t           wb_i,
    output logic              we_o,
    output logic [VRF_AW-1:0] waddr_o,
    output logic [3:0]        bwen_o,
    output vrf_word_u         wdata_o
);

    logic [MASK_DEPTH-1:0] mask_q;
    logic [MASK_AW-1:0]    mask_idx;
    logic                  mask_rd;
    logic                  blocked;
    logic                  mask_we;

    // Mask entry of the destination element
    assign mask_idx = wb_i.vd[MASK_AW-1:0];
    assign mask_rd  = mask_q[mask_idx];
    assign blocked  = wb_i.masked && !mask_rd;

    assign mask_we = wb_i.valid && wb_i.is_mask && !blocked;
    assign we_o    = wb_i.valid && !wb_i.is_mask && !blocked;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mask_q <= '0;
        end else if (mask_we) begin
            mask_q[mask_idx] <= wb_i.mask_bit;
        end
    end

    assign waddr_o = el_word_addr(wb_i.vd, wb_i.sew);

    // Byte enables from element width and offset
    always_comb begin
        case (wb_i.sew)
            SEW_8: begin
                bwen_o = 4'b0001 << wb_i.vd[1:0];
            end
            SEW_16: begin
                bwen_o = wb_i.vd[0] ? 4'b1100 : 4'b0011;
            end
            default: begin
                bwen_o = 4'b1111;
            end
        endcase
    end

    // Element copied into every lane, enables pick the live one
    always_comb begin
        case (wb_i.sew)
            SEW_8: begin
                wdata_o.b = {4{wb_i.result[7:0]}};
            end
            SEW_16: begin
                wdata_o.h = {2{wb_i.result[15:0]}};
            end
            default: begin
                wdata_o.w = wb_i.result;
            end
        endcase
    end

endmodule

// File: design/read_port.sv
`timescale 1ns/100ps

module read_port import lane_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [EL_IDX_W-1:0] el_idx_i,
    input  sew_e                sew_i,
    input  logic                signed_i,
    output logic [VRF_AW-1:0]   vrf_addr_o,
    input  vrf_word_u           vrf_word_i,
    output logic [31:0]         element_o
);

    logic [1:0]  off_q;
    sew_e        sew_q;
    logic        signed_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] element_d;

    assign vrf_addr_o = el_word_addr(el_idx_i, sew_i);

    // Offset and format follow the word through the bank register
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            off_q    <= 2'd0;
            sew_q    <= SEW_32;
            signed_q <= 1'b0;
        end else begin
            off_q    <= el_idx_i[1:0];
            sew_q    <= sew_i;
            signed_q <= signed_i;
        end
    end

    always_comb begin
        byte_sel = vrf_word_i.b[off_q];
        half_sel = vrf_word_i.h[off_q[0]];
        case (sew_q)
            SEW_8: begin
                element_d = {{24{signed_q & byte_sel[7]}}, byte_sel};
            end
            SEW_16: begin
                element_d = {{16{signed_q & half_sel[15]}}, half_sel};
            end
            default: begin
                element_d = vrf_word_i.w;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        element_o <= element_d;
    end

endmodule

// File: design/vector_lane.sv
`timescale 1ns/100ps

module vector_lane import lane_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        op_valid_i,
    input  lane_op_t    op_i,
    output logic        store_valid_o,
    output logic [31:0] store_data_o
);

    logic [R_PORTS-1:0][VRF_AW-1:0] raddr;
    vrf_word_u [R_PORTS-1:0]        rdata;
    logic [R_PORTS-1:0][31:0]       elem;
    exec_ctrl_t                     ctrl;
    wb_req_t                        wb_req;
    logic                           we;
    logic [VRF_AW-1:0]              waddr;
    logic [3:0]                     bwen;
    vrf_word_u                      wdata;

    vrf_bank u_vrf_bank (
        .clk_i   (clk_i),
        .raddr_i (raddr),
        .rdata_o (rdata),
        .we_i    (we),
        .waddr_i (waddr),
        .bwen_i  (bwen),
        .wdata_i (wdata)
    );

    // Port 0 reads vs1, port 1 reads vs2
    read_port u_read_port_a (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .el_idx_i   (op_i.vs1),
        .sew_i      (op_i.sew),
        .signed_i   (op_i.signed_rd),
        .vrf_addr_o (raddr[0]),
        .vrf_word_i (rdata[0]),
        .element_o  (elem[0])
    );

    read_port u_read_port_b (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .el_idx_i   (op_i.vs2),
        .sew_i      (op_i.sew),
        .signed_i   (op_i.signed_rd),
        .vrf_addr_o (raddr[1]),
        .vrf_word_i (rdata[1]),
        .element_o  (elem[1])
    );

    lane_ctrl_pipe u_ctrl_pipe (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .ctrl_o     (ctrl)
    );

    lane_alu u_alu (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ctrl_i        (ctrl),
        .elem_a_i      (elem[0]),
        .elem_b_i      (elem[1]),
        .wb_o          (wb_req),
        .store_valid_o (store_valid_o),
        .store_data_o  (store_data_o)
    );

    lane_writeback u_writeback (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wb_i    (wb_req),
        .we_o    (we),
        .waddr_o (waddr),
        .bwen_o  (bwen),
        .wdata_o (wdata)
    );

endmodule

// File: design/vrf_bank.sv
`timescale 1ns/100ps

module vrf_bank import lane_pkg::*; (
    input  logic                            clk_i,
    input  logic [R_PORTS-1:0][VRF_AW-1:0]  raddr_i,
    output vrf_word_u [R_PORTS-1:0]         rdata_o,
    input  logic                            we_i,
    input  logic [VRF_AW-1:0]               waddr_i,
    input  logic [3:0]                      bwen_i,
    input  vrf_word_u                       wdata_i
);

    vrf_word_u mem [VRF_DEPTH];

    // Byte-lane write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (bwen_i[i]) begin
                    mem[waddr_i].b[i] <= wdata_i.b[i];
                end
            end
        end
    end

    // Read registers, old data on a same-edge collision
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < R_PORTS; p++) begin
            rdata_o[p] <= mem[raddr_i[p]];
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the vector lane testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_vector_lane \
    -f vector_lane.f -Mdir obj_dir \
    && ./obj_dir/Vtb_vector_lane > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/lane_model.svh
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

// Expected lane state, updated when an op issues
logic [31:0]           model_mem [VRF_DEPTH];
logic [MASK_DEPTH-1:0] model_mask = '0;
logic [31:0]           rng_state = 32'h8641810f;

function automatic logic [31:0] xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

function automatic logic [VRF_AW-1:0] word_of(logic [EL_IDX_W-1:0] idx, sew_e sew);
    return VRF_AW'(sew == SEW_8 ? idx / 4 : (sew == SEW_16 ? idx / 2 : idx));
endfunction

function automatic logic [31:0] model_read(logic [EL_IDX_W-1:0] idx, sew_e sew, logic sgn);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model_mem[word_of(idx, sew)];
    b = w[8 * idx[1:0] +: 8];
    h = w[16 * idx[0] +: 16];
    if (sew == SEW_8) return {{24{sgn & b[7]}}, b};
    if (sew == SEW_16) return {{16{sgn & h[15]}}, h};
    return w;
endfunction

// Element a store presents, from the port its select picks
function automatic logic [31:0] expected_store(lane_op_t op);
    return model_read(op.store_sel ? op.vs2 : op.vs1, op.sew, op.signed_rd);
endfunction

function automatic void apply_op(lane_op_t op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [VRF_AW-1:0] wa;
    a  = model_read(op.vs1, op.sew, op.signed_rd);
    b  = model_read(op.vs2, op.sew, op.signed_rd);
    wa = word_of(op.vd, op.sew);
    if (op.src2 == SRC2_SCALAR) b = op.scalar;
    if (op.src2 == SRC2_IMM) b = {{27{op.imm_signed & op.imm5[4]}}, op.imm5};
    case (op.alu_op)
        ALU_ADD:    r = a + b;
        ALU_SUB:    r = a - b;
        ALU_AND:    r = a & b;
        ALU_OR:     r = a | b;
        ALU_XOR:    r = a ^ b;
        ALU_PASS:   r = b;
        ALU_CMP_EQ: r = {31'd0, a == b};
        default:    r = {31'd0, $signed(a) < $signed(b)};
    endcase
    // Masked op with a clear mask bit changes nothing
    if (op.masked && !model_mask[op.vd[MASK_AW-1:0]]) return;
    if (op.kind == KIND_MASK) begin
        model_mask[op.vd[MASK_AW-1:0]] = r[0];
    end else if (op.sew == SEW_8) begin
        model_mem[wa][8 * op.vd[1:0] +: 8] = r[7:0];
    end else if (op.sew == SEW_16) begin
        model_mem[wa][16 * op.vd[0] +: 16] = r[15:0];
    end else begin
        model_mem[wa] = r;
    end
endfunction

`endif

// File: tb/tb_vector_lane.sv
`timescale 1ns/100ps

module tb_vector_lane import lane_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int N_WORDS    = 64;
    localparam int N_PART     = 40;
    localparam int N_ALU_REP  = 2;
    localparam int N_BLOCKED  = 8;
    localparam int N_MASKED   = 24;
    localparam int N_BURST    = 32;
    // Ops issued by the whole sequence, compares issue no store
    localparam int N_OPS = 2 * N_WORDS + 4 * N_PART + 2 * N_BLOCKED
                         + N_ALU_REP * (2 * 18 + 6) + 2 * N_MASKED + N_BURST;

    logic        clk_i;
    logic        rst_i;
    logic        op_valid_i;
    lane_op_t    op_i;
    logic        store_valid_o;
    logic [31:0] store_data_o;

    int          cycle_cnt = 0;
    logic [31:0] exp_q [$];
    int          due_q [$];

    `include "lane_model.svh"

    vector_lane uut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .op_valid_i    (op_valid_i),
        .op_i          (op_i),
        .store_valid_o (store_valid_o),
        .store_data_o  (store_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val) begin
            stop_run($sformatf("error at %0d ns: %s, expected %08h, got %08h",
                               $time, what, exp_val, got));
        end
    endtask

    // Called on a falling edge, holds the strobe for one cycle
    task automatic issue(input lane_op_t op, input int gap);
        op_i       = op;
        op_valid_i = 1'b1;
        if (op.kind == KIND_STORE) begin
            exp_q.push_back(expected_store(op));
            due_q.push_back(cycle_cnt + 2);
        end else begin
            apply_op(op);
        end
        @(negedge clk_i);
        op_valid_i = 1'b0;
        repeat (gap - 1) @(negedge clk_i);
    endtask

    // Only the first N_WORDS words are ever written
    function automatic logic [EL_IDX_W-1:0] rand_idx(sew_e sew);
        if (sew == SEW_8) return EL_IDX_W'(xorshift() % (4 * N_WORDS));
        if (sew == SEW_16) return EL_IDX_W'(xorshift() % (2 * N_WORDS));
        return EL_IDX_W'(xorshift() % N_WORDS);
    endfunction

    function automatic sew_e rand_sew();
        case (xorshift() % 3)
            0:       return SEW_8;
            1:       return SEW_16;
            default: return SEW_32;
        endcase
    endfunction

    function automatic lane_op_t load_op(sew_e sew, logic [EL_IDX_W-1:0] vd, logic masked);
        lane_op_t op;
        op        = '0;
        op.kind   = KIND_ALU;
        op.alu_op = ALU_PASS;
        op.src2   = SRC2_SCALAR;
        op.sew    = sew;
        op.vd     = vd;
        op.masked = masked;
        op.scalar = xorshift();
        return op;
    endfunction

    // Element on a random port, the other port reads elsewhere
    function automatic lane_op_t store_op(sew_e sew, logic [EL_IDX_W-1:0] idx, logic sgn);
        lane_op_t    op;
        logic [31:0] r;
        r            = xorshift();
        op           = '0;
        op.kind      = KIND_STORE;
        op.sew       = sew;
        op.signed_rd = sgn;
        op.store_sel = r[0];
        op.vs1       = r[0] ? rand_idx(sew) : idx;
        op.vs2       = r[0] ? idx : rand_idx(sew);
        return op;
    endfunction

    initial begin
        lane_op_t            op;
        sew_e                sew;
        logic [EL_IDX_W-1:0] idx;
        logic [31:0]         r;

        rst_i      = 1'b0;
        op_valid_i = 1'b0;
        op_i       = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);

        for (int i = 0; i < N_WORDS; i++) begin
            issue(load_op(SEW_32, EL_IDX_W'(i), 1'b0), 6);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            issue(store_op(SEW_32, EL_IDX_W'(i), 1'b0), 1);
        end

        // Byte and halfword loads, read back both ways and as a word
        for (int i = 0; i < N_PART; i++) begin
            r   = xorshift();
            sew = r[0] ? SEW_16 : SEW_8;
            idx = rand_idx(sew);
            issue(load_op(sew, idx, 1'b0), 6);
            issue(store_op(sew, idx, 1'b0), 1);
            issue(store_op(sew, idx, 1'b1), 1);
            issue(store_op(SEW_32, EL_IDX_W'(word_of(idx, sew)), 1'b0), 1);
        end

        // Mask file still clear here
        for (int i = 0; i < N_BLOCKED; i++) begin
            idx = rand_idx(SEW_32);
            issue(load_op(SEW_32, idx, 1'b1), 6);
            issue(store_op(SEW_32, idx, 1'b0), 1);
        end

        // ALU ops with every source, then compares into the mask file
        for (int rep = 0; rep < N_ALU_REP; rep++) begin
            for (int k = 0; k < 8; k++) begin
                for (int s = 0; s < 3; s++) begin
                    r             = xorshift();
                    op            = '0;
                    op.kind       = (k >= 6) ? KIND_MASK : KIND_ALU;
                    op.alu_op     = alu_op_e'(3'(k));
                    op.src2       = src2_e'(2'(s));
                    op.sew        = rand_sew();
                    op.vs1        = rand_idx(op.sew);
                    op.vs2        = r[3] ? op.vs1 : rand_idx(op.sew);
                    op.vd         = rand_idx(op.sew);
                    op.signed_rd  = r[5];
                    // First pass forces negative signed immediates
                    op.imm5       = {r[4] | (rep == 0), r[9:6]};
                    op.imm_signed = r[10] | (rep == 0);
                    op.scalar     = r[11] ? xorshift() : {{22{r[12]}}, r[31:22]};
                    issue(op, 6);
                    if (op.kind == KIND_ALU) begin
                        issue(store_op(op.sew, op.vd, op.signed_rd), 1);
                    end
                end
            end
        end

        for (int i = 0; i < N_MASKED; i++) begin
            sew = rand_sew();
            idx = rand_idx(sew);
            issue(load_op(sew, idx, 1'b1), 6);
            issue(store_op(sew, idx, 1'b0), 1);
        end

        for (int i = 0; i < N_BURST; i++) begin
            r   = xorshift();
            sew = rand_sew();
            issue(store_op(sew, rand_idx(sew), r[0]), 1);
        end

        repeat (6) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            stop_run("some issued stores never appeared on store_valid_o");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // Store checker, samples on the falling edge
    initial begin
        logic [31:0] exp_data;
        int          due;

        wait (rst_i === 1'b1);
        forever begin
            @(negedge clk_i);
            if (store_valid_o !== 1'b0) begin
                if (exp_q.size() == 0) begin
                    stop_run("store_valid_o went high while no store was pending");
                end else begin
                    exp_data = exp_q.pop_front();
                    due      = due_q.pop_front();
                    check_value("store cycle", 32'(cycle_cnt), 32'(due));
                    check_value("store data", store_data_o, exp_data);
                end
            end else if (due_q.size() != 0 && due_q[0] < cycle_cnt) begin
                stop_run("an issued store did not show up on store_valid_o");
            end
        end
    end

    initial begin
        #((N_OPS * 8 + 100) * CLK_PERIOD);
        stop_run("watchdog timeout, the test sequence did not finish in time");
    end

endmodule

// File: vector_lane.f
+incdir+tb
design/lane_pkg.sv
design/vrf_bank.sv
design/read_port.sv
design/lane_ctrl_pipe.sv
design/lane_alu.sv
design/lane_writeback.sv
design/vector_lane.sv
tb/tb_vector_lane.sv
